//--- all.f
+incdir+verilog
verilog/axiBridgePkg.sv
verilog/reqArbiter.sv
verilog/axiReadEngine.sv
verilog/axiWriteEngine.sv
verilog/axiBridge.sv
tests/axiSlaveModel.sv
tests/axiBridgeTb.sv

//--- Bender.yml
package:
  name: axiBridge

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/axiBridgePkg.sv
      - verilog/reqArbiter.sv
      - verilog/axiReadEngine.sv
      - verilog/axiWriteEngine.sv
      - verilog/axiBridge.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/axiSlaveModel.sv
      - tests/axiBridgeTb.sv

//--- tests/bridge_vectors.txt
// Each line holds op, address, write data, strobe and expected result in hex
// Op 1 fetches a line, 2 reads, 3 writes, 4 fetches together with the read below it
1 00000104 00000000 0 A5A5010CA5A50108A5A50104A5A50100
2 00000200 00000000 0 A5A50200
3 00000200 11223344 5 0
1 00000050 00000000 0 A5A5005CA5A50058A5A50054A5A50050
2 00000200 00000000 0 A5220244
3 00000300 DEADBEEF F 0
2 00000300 00000000 0 DEADBEEF
3 00000304 CAFEF00D 8 0
2 00000304 00000000 0 CAA50304
4 000007E4 00000000 0 A5A507ECA5A507E8A5A507E4A5A507E0
2 00000800 00000000 0 A5A50800
1 00000308 00000000 0 A5A5030CA5A50308CAA50304DEADBEEF
3 00000FFC 1234BEEF 3 0
2 00000FFC 00000000 0 A5A5BEEF

//--- tests/axiBridgeTb.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module axiBridgeTb;
    localparam int MaxVectors      = 64;
    localparam int CyclesPerVector = 200;
    localparam int LineW           = `LINE_WORDS * `DATA_W;

    logic                   clk;
    logic                   rst;
    axiBridgePkg::instReqT  instReq;
    logic                   instReqValid;
    logic                   instReqReady;
    axiBridgePkg::instRespT instResp;
    logic                   instRespValid;
    logic                   instRespReady;
    axiBridgePkg::dataReqT  dataReq;
    logic                   dataReqValid;
    logic                   dataReqReady;
    axiBridgePkg::dataRespT dataResp;
    logic                   dataRespValid;
    logic                   dataRespReady;
    axiBridgePkg::arT       ar;
    logic                   arValid;
    logic                   arReady;
    axiBridgePkg::rT        r;
    logic                   rValid;
    logic                   rReady;
    axiBridgePkg::awT       aw;
    logic                   awValid;
    logic                   awReady;
    axiBridgePkg::wT        w;
    logic                   wValid;
    logic                   wReady;
    axiBridgePkg::bT        b;
    logic                   bValid;
    logic                   bReady;

    // Five entries per vector for op, address, write data, strobe and expected
    logic [LineW-1:0] vecMem [5*MaxVectors];
    int               numVectors;
    int               limitCycles = 0;

    axiBridge axiBridge_i (.*);

    axiSlaveModel slave (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abortRun();
        $display("TEST FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic checkLine(string name, axiBridgePkg::instRespT exp,
                             axiBridgePkg::instRespT act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkWord(string name, axiBridgePkg::dataRespT exp,
                             axiBridgePkg::dataRespT act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkAr(string name, axiBridgePkg::arT exp, axiBridgePkg::arT act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkW(string name, axiBridgePkg::wT exp, axiBridgePkg::wT act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            abortRun();
        end
    endtask

    function automatic axiBridgePkg::arT fetchAr(logic [`ADDR_W-1:0] pc);
        axiBridgePkg::arT a;
        a.id    = `INST_ID;
        a.addr  = {pc[`ADDR_W-1:4], 4'h0};
        a.len   = `LINE_LEN;
        a.size  = `SIZE_WORD;
        a.burst = `BURST_WRAP;
        return a;
    endfunction

    function automatic axiBridgePkg::arT readAr(logic [`ADDR_W-1:0] addr);
        axiBridgePkg::arT a;
        a.id    = `DATA_ID;
        a.addr  = addr;
        a.len   = 4'd0;
        a.size  = `SIZE_WORD;
        a.burst = `BURST_INCR;
        return a;
    endfunction

    task automatic nextAr(string name, axiBridgePkg::arT exp);
        if (slave.arLog.size() == 0) begin
            $display("No read address transfer was seen for %s", name);
            abortRun();
        end else begin
            checkAr(name, exp, slave.arLog.pop_front());
        end
    endtask

    // Both requests go up together and drop once taken
    task automatic sendReqs(logic doInst, logic [`ADDR_W-1:0] pc,
                            logic doData, axiBridgePkg::dataReqT req);
        logic instTaken;
        logic dataTaken;
        instReq.pc   = pc;
        dataReq      = req;
        instReqValid = doInst;
        dataReqValid = doData;
        while (instReqValid || dataReqValid) begin
            instTaken = instReqValid && instReqReady;
            dataTaken = dataReqValid && dataReqReady;
            @(negedge clk);
            if (instTaken) begin
                instReqValid = 1'b0;
            end
            if (dataTaken) begin
                dataReqValid = 1'b0;
            end
        end
    endtask

    task automatic takeLine(string name, axiBridgePkg::instRespT exp);
        axiBridgePkg::instRespT first;
        while (instRespValid !== 1'b1) @(negedge clk);
        first = instResp;
        repeat ($urandom_range(4, 1)) begin
            @(negedge clk);
            if (instRespValid !== 1'b1) begin
                $display("Line response valid dropped while held back in %s", name);
                abortRun();
            end
            checkLine({name, " held"}, first, instResp);
        end
        instRespReady = 1'b1;
        @(negedge clk);
        instRespReady = 1'b0;
        checkLine(name, exp, first);
    endtask

    task automatic takeWord(string name, axiBridgePkg::dataRespT exp);
        axiBridgePkg::dataRespT first;
        while (dataRespValid !== 1'b1) @(negedge clk);
        first = dataResp;
        repeat ($urandom_range(4, 1)) begin
            @(negedge clk);
            if (dataRespValid !== 1'b1) begin
                $display("Data response valid dropped while held back in %s", name);
                abortRun();
            end
            checkWord({name, " held"}, first, dataResp);
        end
        dataRespReady = 1'b1;
        @(negedge clk);
        dataRespReady = 1'b0;
        checkWord(name, exp, first);
    endtask

    initial begin : watchdog
        wait (limitCycles > 0);
        repeat (limitCycles) @(posedge clk);
        $display("Run timed out after %0d cycles without finishing the vectors", limitCycles);
        abortRun();
    end

    initial begin : mainFlow
        int                    i;
        int                    k;
        logic [3:0]            op;
        axiBridgePkg::dataReqT req;
        axiBridgePkg::wT       wExp;
        string                 name;
        string                 pairName;
        void'($urandom(32'h5a56));
        rst           = 1'b1;
        instReq       = '0;
        instReqValid  = 1'b0;
        instRespReady = 1'b0;
        dataReq       = '0;
        dataReqValid  = 1'b0;
        dataRespReady = 1'b0;
        for (i = 0; i < 5 * MaxVectors; i++) begin
            vecMem[i] = '0;
        end
        $readmemh("tests/bridge_vectors.txt", vecMem);
        numVectors = 0;
        while (numVectors < MaxVectors && vecMem[5*numVectors] != '0) begin
            numVectors++;
        end
        if (numVectors == 0) begin
            $display("No vectors found in tests/bridge_vectors.txt");
            abortRun();
        end
        limitCycles = numVectors * CyclesPerVector;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        i = 0;
        while (i < numVectors) begin
            k        = 5 * i;
            op       = vecMem[k][3:0];
            name     = $sformatf("vector %0d", i);
            req.addr = vecMem[k+1][`ADDR_W-1:0];
            req.wEn  = op == 4'd3;
            req.strb = vecMem[k+3][`STRB_W-1:0];
            req.data = vecMem[k+2][`DATA_W-1:0];
            case (op)
                4'd1: begin
                    sendReqs(1'b1, req.addr, 1'b0, '0);
                    takeLine(name, vecMem[k+4]);
                    nextAr(name, fetchAr(req.addr));
                end
                4'd2: begin
                    sendReqs(1'b0, '0, 1'b1, req);
                    takeWord(name, vecMem[k+4][`DATA_W-1:0]);
                    nextAr(name, readAr(req.addr));
                end
                4'd3: begin
                    // Writes give no CPU response and are checked on aw and w
                    sendReqs(1'b0, '0, 1'b1, req);
                    while (slave.wLog.size() == 0) @(negedge clk);
                    wExp.data = req.data;
                    wExp.strb = req.strb;
                    wExp.last = 1'b1;
                    checkAr({name, " aw"}, readAr(req.addr), slave.awLog.pop_front());
                    checkW({name, " w"}, wExp, slave.wLog.pop_front());
                end
                4'd4: begin
                    pairName = $sformatf("vector %0d", i + 1);
                    req.addr = vecMem[k+6][`ADDR_W-1:0];
                    req.wEn  = 1'b0;
                    sendReqs(1'b1, vecMem[k+1][`ADDR_W-1:0], 1'b1, req);
                    // Data read is served ahead of the refill
                    takeWord(pairName, vecMem[k+9][`DATA_W-1:0]);
                    takeLine(name, vecMem[k+4]);
                    nextAr(pairName, readAr(req.addr));
                    nextAr(name, fetchAr(vecMem[k+1][`ADDR_W-1:0]));
                    i++;
                end
                default: begin
                    $display("Unknown operation %0d in %s", op, name);
                    abortRun();
                end
            endcase
            i++;
        end

        if (slave.arLog.size() != 0) begin
            $display("%0d read address transfers were not expected", slave.arLog.size());
            abortRun();
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- tests/axiSlaveModel.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module axiSlaveModel (
    input  logic             clk,
    input  logic             rst,
    input  axiBridgePkg::arT ar,
    input  logic             arValid,
    output logic             arReady,
    output axiBridgePkg::rT  r,
    output logic             rValid,
    input  logic             rReady,
    input  axiBridgePkg::awT aw,
    input  logic             awValid,
    output logic             awReady,
    input  axiBridgePkg::wT  w,
    input  logic             wValid,
    output logic             wReady,
    output axiBridgePkg::bT  b,
    output logic             bValid,
    input  logic             bReady
);
    // Covers the low 4 KB
    localparam int Words = 1024;

    logic [`DATA_W-1:0] mem [Words];
    axiBridgePkg::arT   arLog [$];
    axiBridgePkg::awT   awLog [$];
    axiBridgePkg::wT    wLog [$];

    function automatic logic [`ADDR_W-1:0] beatAddr(axiBridgePkg::arT req, int beat);
        logic [`ADDR_W-1:0] span;
        logic [`ADDR_W-1:0] step;
        span = (`ADDR_W'(req.len) + 1) << 2;
        step = `ADDR_W'(beat) << 2;
        if (req.burst == `BURST_WRAP) begin
            return (req.addr & ~(span - 1)) | ((req.addr + step) & (span - 1));
        end
        return req.addr + step;
    endfunction

    initial begin
        for (int i = 0; i < Words; i++) begin
            mem[i] = (i << 2) ^ 32'hA5A50000;
        end
    end

    initial begin : readChannel
        axiBridgePkg::arT   req;
        logic [`ADDR_W-1:0] addr;
        arReady = 1'b0;
        rValid  = 1'b0;
        r       = '0;
        forever begin
            @(negedge clk);
            if (arValid === 1'b1) begin
                repeat ($urandom_range(2)) @(negedge clk);
                req = ar;
                arLog.push_back(req);
                arReady = 1'b1;
                @(negedge clk);
                arReady = 1'b0;
                for (int beat = 0; beat <= req.len; beat++) begin
                    repeat ($urandom_range(2)) @(negedge clk);
                    addr   = beatAddr(req, beat);
                    r.id   = req.id;
                    r.data = mem[addr[11:2]];
                    r.last = beat == req.len;
                    rValid = 1'b1;
                    // Ready seen here means the beat goes at the next edge
                    while (rReady !== 1'b1) @(negedge clk);
                    @(negedge clk);
                    rValid = 1'b0;
                end
            end
        end
    end

    initial begin : writeChannel
        axiBridgePkg::awT req;
        axiBridgePkg::wT  beat;
        awReady = 1'b0;
        wReady  = 1'b0;
        bValid  = 1'b0;
        b       = '0;
        forever begin
            @(negedge clk);
            if (awValid === 1'b1) begin
                repeat ($urandom_range(2)) @(negedge clk);
                req = aw;
                awLog.push_back(req);
                awReady = 1'b1;
                @(negedge clk);
                awReady = 1'b0;
                while (wValid !== 1'b1) @(negedge clk);
                repeat ($urandom_range(2)) @(negedge clk);
                beat = w;
                wLog.push_back(beat);
                wReady = 1'b1;
                @(negedge clk);
                wReady = 1'b0;
                // Byte merge under the strobe
                for (int k = 0; k < `STRB_W; k++) begin
                    if (beat.strb[k]) begin
                        mem[req.addr[11:2]][8*k +: 8] = beat.data[8*k +: 8];
                    end
                end
                repeat ($urandom_range(2)) @(negedge clk);
                b.id   = req.id;
                b.resp = 2'b00;
                bValid = 1'b1;
                while (bReady !== 1'b1) @(negedge clk);
                @(negedge clk);
                bValid = 1'b0;
            end
        end
    end

endmodule

//--- verilog/axiBridge.sv
`timescale 1ns/1ps

module axiBridge (
    input  logic                   clk,
    input  logic                   rst,
    input  axiBridgePkg::instReqT  instReq,
    input  logic                   instReqValid,
    output logic                   instReqReady,
    output axiBridgePkg::instRespT instResp,
    output logic                   instRespValid,
    input  logic                   instRespReady,
    input  axiBridgePkg::dataReqT  dataReq,
    input  logic                   dataReqValid,
    output logic                   dataReqReady,
    output axiBridgePkg::dataRespT dataResp,
    output logic                   dataRespValid,
    input  logic                   dataRespReady,
    output axiBridgePkg::arT       ar,
    output logic                   arValid,
    input  logic                   arReady,
    input  axiBridgePkg::rT        r,
    input  logic                   rValid,
    output logic                   rReady,
    output axiBridgePkg::awT       aw,
    output logic                   awValid,
    input  logic                   awReady,
    output axiBridgePkg::wT        w,
    output logic                   wValid,
    input  logic                   wReady,
    input  axiBridgePkg::bT        b,
    input  logic                   bValid,
    output logic                   bReady
);
    axiBridgePkg::readCmdT  readCmd;
    logic                   readCmdValid;
    logic                   readCmdReady;
    axiBridgePkg::writeCmdT writeCmd;
    logic                   writeCmdValid;
    logic                   writeCmdReady;
    logic                   readDone;
    logic                   readDoneInst;
    logic                   writeDone;

    reqArbiter arbiter (
        .clk           (clk),
        .rst           (rst),
        .instReq       (instReq),
        .instReqValid  (instReqValid),
        .instReqReady  (instReqReady),
        .dataReq       (dataReq),
        .dataReqValid  (dataReqValid),
        .dataReqReady  (dataReqReady),
        .readCmd       (readCmd),
        .readCmdValid  (readCmdValid),
        .readCmdReady  (readCmdReady),
        .writeCmd      (writeCmd),
        .writeCmdValid (writeCmdValid),
        .writeCmdReady (writeCmdReady),
        .readDone      (readDone),
        .readDoneInst  (readDoneInst),
        .writeDone     (writeDone)
    );

    axiReadEngine readEngine (
        .clk           (clk),
        .rst           (rst),
        .readCmd       (readCmd),
        .readCmdValid  (readCmdValid),
        .readCmdReady  (readCmdReady),
        .ar            (ar),
        .arValid       (arValid),
        .arReady       (arReady),
        .r             (r),
        .rValid        (rValid),
        .rReady        (rReady),
        .instResp      (instResp),
        .instRespValid (instRespValid),
        .instRespReady (instRespReady),
        .dataResp      (dataResp),
        .dataRespValid (dataRespValid),
        .dataRespReady (dataRespReady),
        .readDone      (readDone),
        .readDoneInst  (readDoneInst)
    );

    axiWriteEngine writeEngine (
        .clk           (clk),
        .rst           (rst),
        .writeCmd      (writeCmd),
        .writeCmdValid (writeCmdValid),
        .writeCmdReady (writeCmdReady),
        .aw            (aw),
        .awValid       (awValid),
        .awReady       (awReady),
        .w             (w),
        .wValid        (wValid),
        .wReady        (wReady),
        .b             (b),
        .bValid        (bValid),
        .bReady        (bReady),
        .writeDone     (writeDone)
    );

endmodule

//--- verilog/axiWriteEngine.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module axiWriteEngine (
    input  logic                   clk,
    input  logic                   rst,
    input  axiBridgePkg::writeCmdT writeCmd,
    input  logic                   writeCmdValid,
    output logic                   writeCmdReady,
    output axiBridgePkg::awT       aw,
    output logic                   awValid,
    input  logic                   awReady,
    output axiBridgePkg::wT        w,
    output logic                   wValid,
    input  logic                   wReady,
    input  axiBridgePkg::bT        b,
    input  logic                   bValid,
    output logic                   bReady,
    output logic                   writeDone
);
    typedef enum logic [1:0] {
        sIdle,
        sAddr,
        sData,
        sResp
    } writeState;

    writeState              state;
    axiBridgePkg::writeCmdT cmd;

    assign writeCmdReady = state == sIdle;
    assign awValid       = state == sAddr;
    assign wValid        = state == sData;
    assign bReady        = state == sResp;
    assign writeDone     = bValid && bReady;

    always_comb begin
        aw.id    = `DATA_ID;
        aw.addr  = cmd.addr;
        aw.len   = 4'd0;
        aw.size  = `SIZE_WORD;
        aw.burst = `BURST_INCR;
    end

    // One beat, so it is always the last
    always_comb begin
        w.data = cmd.data;
        w.strb = cmd.strb;
        w.last = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sIdle;
        end else begin
            case (state)
                sIdle: begin
                    if (writeCmdValid) begin
                        state <= sAddr;
                    end
                end
                sAddr: begin
                    if (awReady) begin
                        state <= sData;
                    end
                end
                sData: begin
                    if (wReady) begin
                        state <= sResp;
                    end
                end
                sResp: begin
                    if (bValid) begin
                        state <= sIdle;
                    end
                end
                default: state <= sIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (writeCmdValid && writeCmdReady) begin
            cmd <= writeCmd;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        $rose(wValid) |-> $past(awValid && awReady));

    // Only data accesses use this channel
    assert property (@(posedge clk) disable iff (rst)
        bValid && bReady |-> b.id == `DATA_ID);

endmodule

//--- verilog/axiReadEngine.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module axiReadEngine (
    input  logic                   clk,
    input  logic                   rst,
    input  axiBridgePkg::readCmdT  readCmd,
    input  logic                   readCmdValid,
    output logic                   readCmdReady,
    output axiBridgePkg::arT       ar,
    output logic                   arValid,
    input  logic                   arReady,
    input  axiBridgePkg::rT        r,
    input  logic                   rValid,
    output logic                   rReady,
    output axiBridgePkg::instRespT instResp,
    output logic                   instRespValid,
    input  logic                   instRespReady,
    output axiBridgePkg::dataRespT dataResp,
    output logic                   dataRespValid,
    input  logic                   dataRespReady,
    output logic                   readDone,
    output logic                   readDoneInst
);
    localparam int IdxW = $clog2(`LINE_WORDS);

    typedef enum logic [1:0] {
        sIdle,
        sAddr,
        sBeats,
        sResp
    } readState;

    readState               state;
    axiBridgePkg::readCmdT  cmd;
    axiBridgePkg::lineUnion line;
    logic [IdxW:0]          beatCount;
    logic                   respValid;
    logic                   respTaken;

    assign readCmdReady = state == sIdle;
    assign arValid      = state == sAddr;
    assign rReady       = state == sBeats;
    assign respValid    = state == sResp;

    assign instRespValid = respValid && cmd.isInst;
    assign dataRespValid = respValid && !cmd.isInst;
    assign respTaken     = (instRespValid && instRespReady) ||
                           (dataRespValid && dataRespReady);

    assign readDone     = respTaken;
    assign readDoneInst = cmd.isInst;

    assign instResp.line = line.flat;
    // Single-beat read lands in word zero
    assign dataResp.word = line.words[0];

    always_comb begin
        ar.id    = cmd.isInst ? `INST_ID : `DATA_ID;
        ar.addr  = cmd.addr;
        ar.len   = cmd.isInst ? `LINE_LEN : 4'd0;
        ar.size  = `SIZE_WORD;
        ar.burst = cmd.isInst ? `BURST_WRAP : `BURST_INCR;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= sIdle;
            beatCount <= '0;
        end else begin
            case (state)
                sIdle: begin
                    if (readCmdValid) begin
                        state     <= sAddr;
                        beatCount <= '0;
                    end
                end
                sAddr: begin
                    if (arReady) begin
                        state <= sBeats;
                    end
                end
                sBeats: begin
                    if (rValid) begin
                        beatCount <= beatCount + 1'b1;
                        if (r.last) begin
                            state <= sResp;
                        end
                    end
                end
                sResp: begin
                    if (respTaken) begin
                        state <= sIdle;
                    end
                end
                default: state <= sIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (readCmdValid && readCmdReady) begin
            cmd <= readCmd;
        end
        if (rValid && rReady) begin
            line.words[beatCount[IdxW-1:0]] <= r.data;
        end
    end

    // Slave must close the burst within one line
    assert property (@(posedge clk) disable iff (rst)
        rValid && rReady |-> beatCount < `LINE_WORDS);

    assert property (@(posedge clk) disable iff (rst)
        rValid && rReady |-> r.id == ar.id);

endmodule

//--- verilog/reqArbiter.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module reqArbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  axiBridgePkg::instReqT  instReq,
    input  logic                   instReqValid,
    output logic                   instReqReady,
    input  axiBridgePkg::dataReqT  dataReq,
    input  logic                   dataReqValid,
    output logic                   dataReqReady,
    output axiBridgePkg::readCmdT  readCmd,
    output logic                   readCmdValid,
    input  logic                   readCmdReady,
    output axiBridgePkg::writeCmdT writeCmd,
    output logic                   writeCmdValid,
    input  logic                   writeCmdReady,
    input  logic                   readDone,
    input  logic                   readDoneInst,
    input  logic                   writeDone
);
    localparam int LineBytes = `LINE_WORDS * `DATA_W / 8;

    logic                  instBusy;
    logic                  instIssued;
    logic [`ADDR_W-1:0]    instAddr;
    logic                  dataBusy;
    logic                  dataIssued;
    axiBridgePkg::dataReqT dataSlot;
    logic                  instPending;
    logic                  dataReadPending;
    logic                  pickData;
    logic                  readHold;
    logic                  readHoldData;
    logic                  instDone;
    logic                  dataDone;

    assign instReqReady = !instBusy;
    assign dataReqReady = !dataBusy;

    assign instDone = readDone && readDoneInst;
    assign dataDone = (readDone && !readDoneInst) || writeDone;

    assign instPending     = instBusy && !instIssued;
    assign dataReadPending = dataBusy && !dataIssued && !dataSlot.wEn;

    // Data read wins, but a stalled command keeps its pick
    assign pickData = readHold ? readHoldData : dataReadPending;

    assign readCmdValid = instPending || dataReadPending;

    always_comb begin
        readCmd.addr   = pickData ? dataSlot.addr : instAddr;
        readCmd.isInst = !pickData;
    end

    assign writeCmdValid = dataBusy && !dataIssued && dataSlot.wEn;

    always_comb begin
        writeCmd.addr = dataSlot.addr;
        writeCmd.data = dataSlot.data;
        writeCmd.strb = dataSlot.strb;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instBusy   <= 1'b0;
            instIssued <= 1'b0;
            dataBusy   <= 1'b0;
            dataIssued <= 1'b0;
            readHold   <= 1'b0;
        end else begin
            if (instReqValid && instReqReady) begin
                instBusy   <= 1'b1;
                instIssued <= 1'b0;
            end else if (instDone) begin
                instBusy <= 1'b0;
            end
            if (readCmdValid && readCmdReady && !pickData) begin
                instIssued <= 1'b1;
            end

            if (dataReqValid && dataReqReady) begin
                dataBusy   <= 1'b1;
                dataIssued <= 1'b0;
            end else if (dataDone) begin
                dataBusy <= 1'b0;
            end
            if ((readCmdValid && readCmdReady && pickData) ||
                (writeCmdValid && writeCmdReady)) begin
                dataIssued <= 1'b1;
            end

            readHold <= readCmdValid && !readCmdReady;
        end
    end

    always_ff @(posedge clk) begin
        if (instReqValid && instReqReady) begin
            // Refill always starts at the line boundary
            instAddr <= instReq.pc & ~`ADDR_W'(LineBytes - 1);
        end
        if (dataReqValid && dataReqReady) begin
            dataSlot <= dataReq;
        end
        readHoldData <= pickData;
    end

    // Slot reopens only after its own issued command completes
    assert property (@(posedge clk) disable iff (rst)
        instDone |-> instBusy && instIssued);

    assert property (@(posedge clk) disable iff (rst)
        dataDone |-> dataBusy && dataIssued);

endmodule

//--- verilog/axiBridgePkg.sv
`include "bridge_config.svh"

package axiBridgePkg;

    // Refill line, filled per word and handed out flat
    typedef union packed {
        logic [`LINE_WORDS*`DATA_W-1:0]      flat;
        logic [`LINE_WORDS-1:0][`DATA_W-1:0] words;
    } lineUnion;

    typedef struct packed {
        logic [`ADDR_W-1:0] pc;
    } instReqT;

    typedef struct packed {
        logic [`LINE_WORDS*`DATA_W-1:0] line;
    } instRespT;

    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic               wEn;
        logic [`STRB_W-1:0] strb;
        logic [`DATA_W-1:0] data;
    } dataReqT;

    typedef struct packed {
        logic [`DATA_W-1:0] word;
    } dataRespT;

    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic               isInst;
    } readCmdT;

    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] data;
        logic [`STRB_W-1:0] strb;
    } writeCmdT;

    typedef struct packed {
        logic [`ID_W-1:0]   id;
        logic [`ADDR_W-1:0] addr;
        logic [3:0]         len;
        logic [2:0]         size;
        logic [1:0]         burst;
    } arT;

    typedef arT awT;

    typedef struct packed {
        logic [`ID_W-1:0]   id;
        logic [`DATA_W-1:0] data;
        logic               last;
    } rT;

    typedef struct packed {
        logic [`DATA_W-1:0] data;
        logic [`STRB_W-1:0] strb;
        logic               last;
    } wT;

    typedef struct packed {
        logic [`ID_W-1:0] id;
        logic [1:0]       resp;
    } bT;

endpackage

//--- verilog/bridge_config.svh
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// Bus and line geometry
`define ADDR_W      32
`define DATA_W      32
`define LINE_WORDS  4
`define STRB_W      4
`define ID_W        4

// AXI IDs per request source
`define INST_ID     4'd0
`define DATA_ID     4'd1

// Burst encodings
`define LINE_LEN    4'd3
`define SIZE_WORD   3'd2
`define BURST_WRAP  2'd2
`define BURST_INCR  2'd1

`endif
